// File: build.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/rd_bus_if.sv
verilog/icache.sv
verilog/mem_xbar.sv
verilog/clint.sv
verilog/mem_top.sv
bench/axi_mem_model.sv
bench/mem_top_tb.sv

// File: bench/mem_top_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module mem_top_tb;

	logic                 clock;
	logic                 arst_n;
	logic                 fetch_valid;
	logic [`ADDR_W-1:0]   fetch_addr;
	logic                 fetch_ready;
	logic [`DATA_W-1:0]   fetch_inst;
	mem_pkg::axi_resp_t   fetch_resp;
	logic                 fetch_done;
	logic                 fence_i;
	logic                 ld_valid;
	logic [`ADDR_W-1:0]   ld_addr;
	logic [2:0]           ld_size;
	logic                 ld_ready;
	logic [`DATA_W-1:0]   ld_data;
	mem_pkg::axi_resp_t   ld_resp;
	logic                 ld_done;
	logic                 st_valid;
	logic [`ADDR_W-1:0]   st_addr;
	logic [`DATA_W-1:0]   st_data;
	logic [`DATA_W/8-1:0] st_strb;
	logic                 st_ready;
	mem_pkg::axi_resp_t   st_resp;
	logic                 st_done;
	logic [`ADDR_W-1:0]   awaddr;
	logic [7:0]           awlen;
	logic [2:0]           awsize;
	logic                 awvalid;
	logic                 awready;
	logic [`DATA_W-1:0]   wdata;
	logic [`DATA_W/8-1:0] wstrb;
	logic                 wlast;
	logic                 wvalid;
	logic                 wready;
	mem_pkg::axi_resp_t   bresp;
	logic                 bvalid;
	logic                 bready;
	logic [`ADDR_W-1:0]   araddr;
	logic [7:0]           arlen;
	logic [2:0]           arsize;
	logic                 arvalid;
	logic                 arready;
	logic [`DATA_W-1:0]   rdata;
	mem_pkg::axi_resp_t   rresp;
	logic                 rlast;
	logic                 rvalid;
	logic                 rready;

	logic [3:0]  stall;
	logic        stall_en;
	logic        quiet_ar;
	logic        quiet_aw;
	logic [31:0] addr_lfsr = 32'd79106;
	logic [31:0] stall_lfsr = 32'd79106;
	logic [7:0]  mirror [logic [31:0]];
	logic [31:0] ar_addr_q [$];
	logic [7:0]  ar_len_q [$];
	logic [2:0]  ar_size_q [$];
	logic [7:0]  aw_len_seen;
	logic [2:0]  aw_size_seen;
	logic        w_last_seen;
	int          cycles = 0;
	int          issued = 0;
	int          checks = 0;
	int          errors = 0;

	mem_top UUT (.*);

	axi_mem_model u_mem (.*);

	always #5 clock = ~clock;

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken.
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			state = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
			val = {val[30:0], state[0]};
		end
		return val;
	endfunction

	// Word-aligned address well above the CLINT.
	function automatic logic [31:0] rand_addr();
		logic [31:0] r;
		r = take_bits(addr_lfsr, 26);
		return {4'h8, r[25:0], 2'b00};
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] base;
		logic [31:0] w;
		base = {addr[31:2], 2'b00};
		w = {2'b00, addr[31:2]} * 32'h9E37_79B9 + 32'h1234_5678;
		for (int b = 0; b < 4; b++) begin
			if (mirror.exists(base + 32'(b)))
				w[8*b +: 8] = mirror[base + 32'(b)];
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Valid must hold with a stable address until accepted.
	ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			errors++;
			$display("AR request dropped or changed before arready");
		end

	aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			errors++;
			$display("AW request dropped or changed before awready");
		end

	no_ar: assert property (@(posedge clock) disable iff (!arst_n) quiet_ar |-> !arvalid)
		else begin
			errors++;
			$display("arvalid raised where no AXI read was expected");
		end

	no_aw: assert property (@(posedge clock) disable iff (!arst_n) quiet_aw |-> !awvalid)
		else begin
			errors++;
			$display("awvalid raised for a store into the CLINT range");
		end

	always @(posedge clock)
		stall <= stall_en ? 4'(take_bits(stall_lfsr, 4)) : 4'h0;

	always @(posedge clock) begin
		if (arvalid && arready) begin
			ar_addr_q.push_back(araddr);
			ar_len_q.push_back(arlen);
			ar_size_q.push_back(arsize);
		end
	end

	// Shape of the last write burst.
	always @(posedge clock) begin
		if (awvalid && awready) begin
			aw_len_seen <= awlen;
			aw_size_seen <= awsize;
		end
		if (wvalid && wready)
			w_last_seen <= wlast;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > 64 * issued + 200) begin
			$display("Timeout after %0d cycles with %0d requests issued", cycles, issued);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic clear_ar_log();
		ar_addr_q.delete();
		ar_len_q.delete();
		ar_size_q.delete();
	endtask

	task automatic pulse_fence();
		@(posedge clock);
		fence_i <= 1'b1;
		@(posedge clock);
		fence_i <= 1'b0;
	endtask

	task automatic fetch_word(input logic [31:0] addr, output logic [31:0] inst,
			output mem_pkg::axi_resp_t resp, output int lat);
		int t_acc;
		issued++;
		@(posedge clock);
		fetch_valid <= 1'b1;
		fetch_addr <= addr;
		do begin
			@(posedge clock);
		end while (!fetch_ready);
		fetch_valid <= 1'b0;
		t_acc = cycles;
		do begin
			@(posedge clock);
		end while (!fetch_done);
		lat = cycles - t_acc;
		inst = fetch_inst;
		resp = fetch_resp;
	endtask

	task automatic load_word(input logic [31:0] addr, input logic [2:0] size,
			output logic [31:0] data, output mem_pkg::axi_resp_t resp, output int t_acc);
		issued++;
		@(posedge clock);
		ld_valid <= 1'b1;
		ld_addr <= addr;
		ld_size <= size;
		do begin
			@(posedge clock);
		end while (!ld_ready);
		ld_valid <= 1'b0;
		t_acc = cycles;
		do begin
			@(posedge clock);
		end while (!ld_done);
		data = ld_data;
		resp = ld_resp;
	endtask

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output mem_pkg::axi_resp_t resp);
		issued++;
		@(posedge clock);
		st_valid <= 1'b1;
		st_addr <= addr;
		st_data <= data;
		st_strb <= strb;
		do begin
			@(posedge clock);
		end while (!st_ready);
		st_valid <= 1'b0;
		do begin
			@(posedge clock);
		end while (!st_done);
		resp = st_resp;
	endtask

	// Test 1 and 2.
	task automatic miss_hit_fence();
		logic [31:0]        a1;
		logic [31:0]        a2;
		logic [31:0]        r;
		logic [31:0]        inst;
		mem_pkg::axi_resp_t resp;
		int                 lat;
		a1 = rand_addr();
		clear_ar_log();
		fetch_word(a1, inst, resp, lat);
		check_value("miss data", expected_word(a1), inst);
		check_value("miss resp", mem_pkg::OKAY, resp);
		check_value("miss ar count", 1, ar_addr_q.size());
		check_value("miss araddr", {a1[31:4], 4'h0}, ar_addr_q[0]);
		check_value("miss arlen", 3, ar_len_q[0]);
		r = take_bits(addr_lfsr, 2);
		a2 = {a1[31:4], r[1:0], 2'b00};
		quiet_ar <= 1'b1;
		fetch_word(a2, inst, resp, lat);
		quiet_ar <= 1'b0;
		check_value("hit data", expected_word(a2), inst);
		check_value("hit latency", 1, lat);
		pulse_fence();
		clear_ar_log();
		fetch_word(a1, inst, resp, lat);
		check_value("fence data", expected_word(a1), inst);
		check_value("fence ar count", 1, ar_addr_q.size());
		check_value("fence arlen", 3, ar_len_q[0]);
	endtask

	// Test 3 stores and loads back under stalls.
	task automatic store_load_back();
		logic [31:0]        addr;
		logic [31:0]        data;
		logic [31:0]        r;
		logic [3:0]         strb;
		logic [2:0]         size;
		logic [31:0]        got;
		mem_pkg::axi_resp_t resp;
		int                 t_acc;
		stall_en <= 1'b1;
		for (int i = 0; i < 3; i++) begin
			addr = rand_addr();
			data = take_bits(addr_lfsr, 32);
			r = take_bits(addr_lfsr, 6);
			strb = r[3:0];
			size = r[5:4] == 2'd3 ? 3'd2 : {1'b0, r[5:4]};
			store_word(addr, data, strb, resp);
			check_value($sformatf("store %0d resp", i), mem_pkg::OKAY, resp);
			check_value($sformatf("store %0d awlen", i), 0, aw_len_seen);
			check_value($sformatf("store %0d awsize", i), 2, aw_size_seen);
			check_value($sformatf("store %0d wlast", i), 1, w_last_seen);
			for (int b = 0; b < 4; b++) begin
				if (strb[b])
					mirror[addr + 32'(b)] = data[8*b +: 8];
			end
			clear_ar_log();
			load_word(addr, size, got, resp, t_acc);
			check_value($sformatf("load %0d data", i), expected_word(addr), got);
			check_value($sformatf("load %0d resp", i), mem_pkg::OKAY, resp);
			check_value($sformatf("load %0d ar count", i), 1, ar_addr_q.size());
			check_value($sformatf("load %0d arlen", i), 0, ar_len_q[0]);
			check_value($sformatf("load %0d arsize", i), size, ar_size_q[0]);
		end
		stall_en <= 1'b0;
	endtask

	// Test 4.
	task automatic clint_access();
		logic [31:0]        v1;
		logic [31:0]        v2;
		logic [31:0]        step;
		mem_pkg::axi_resp_t resp;
		int                 t1;
		int                 t2;
		quiet_ar <= 1'b1;
		load_word(`CLINT_BASE + `MTIME_LO_OFS, 3'd2, v1, resp, t1);
		check_value("mtime first resp", mem_pkg::OKAY, resp);
		load_word(`CLINT_BASE + `MTIME_LO_OFS, 3'd2, v2, resp, t2);
		check_value("mtime second resp", mem_pkg::OKAY, resp);
		step = v2 - v1;
		checks++;
		assert (step >= 32'(t2 - t1)) else begin
			errors++;
			$display("Mismatch mtime step: expected >= %0d, actual %0d", t2 - t1, step);
		end
		load_word(`CLINT_BASE + 32'h0100, 3'd2, v1, resp, t1);
		check_value("clint bad offset resp", mem_pkg::SLVERR, resp);
		quiet_ar <= 1'b0;
		quiet_aw <= 1'b1;
		store_word(`CLINT_BASE + 32'h0010, 32'hDEAD_BEEF, 4'hF, resp);
		check_value("clint store resp", mem_pkg::SLVERR, resp);
		quiet_aw <= 1'b0;
	endtask

	// Test 5 has the fill request and the load meet at the crossbar.
	task automatic fetch_load_race();
		logic [31:0]        af;
		logic [31:0]        al;
		logic [31:0]        inst;
		logic [31:0]        got;
		mem_pkg::axi_resp_t fresp;
		mem_pkg::axi_resp_t lresp;
		int                 lat;
		int                 t_acc;
		pulse_fence();
		af = rand_addr();
		al = rand_addr();
		stall_en <= 1'b1;
		clear_ar_log();
		fork
			fetch_word(af, inst, fresp, lat);
			begin
				// The miss raises its fill request one cycle after acceptance.
				@(posedge clock);
				load_word(al, 3'd2, got, lresp, t_acc);
			end
		join
		stall_en <= 1'b0;
		check_value("race fetch data", expected_word(af), inst);
		check_value("race fetch resp", mem_pkg::OKAY, fresp);
		check_value("race load data", expected_word(al), got);
		check_value("race load resp", mem_pkg::OKAY, lresp);
		check_value("race ar count", 2, ar_addr_q.size());
		check_value("race first araddr", al, ar_addr_q[0]);
		check_value("race first arlen", 0, ar_len_q[0]);
		check_value("race second araddr", {af[31:4], 4'h0}, ar_addr_q[1]);
		check_value("race second arlen", 3, ar_len_q[1]);
	endtask

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		fence_i = 1'b0;
		ld_valid = 1'b0;
		ld_addr = '0;
		ld_size = 3'd2;
		st_valid = 1'b0;
		st_addr = '0;
		st_data = '0;
		st_strb = '0;
		stall_en = 1'b0;
		quiet_ar = 1'b0;
		quiet_aw = 1'b0;
		repeat (5) @(posedge clock);
		arst_n <= 1'b1;
		@(posedge clock);
		miss_hit_fence();
		store_load_back();
		clint_access();
		fetch_load_race();
		repeat (4) @(posedge clock);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module axi_mem_model (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic [3:0]           stall,
	input  logic [`ADDR_W-1:0]   awaddr,
	input  logic [7:0]           awlen,
	input  logic [2:0]           awsize,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [`DATA_W-1:0]   wdata,
	input  logic [`DATA_W/8-1:0] wstrb,
	input  logic                 wlast,
	input  logic                 wvalid,
	output logic                 wready,
	output mem_pkg::axi_resp_t   bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [`ADDR_W-1:0]   araddr,
	input  logic [7:0]           arlen,
	input  logic [2:0]           arsize,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [`DATA_W-1:0]   rdata,
	output mem_pkg::axi_resp_t   rresp,
	output logic                 rlast,
	output logic                 rvalid,
	input  logic                 rready
);

	// Sparse storage by word address, untouched words follow the fill pattern.
	logic [31:0]        mem [logic [29:0]];
	logic               rd_busy;
	logic [`ADDR_W-1:0] rd_addr;
	logic [7:0]         rd_left;
	logic               aw_got;
	logic               w_got;
	logic [`ADDR_W-1:0] wr_addr;
	logic [`DATA_W-1:0] wr_data;
	logic [3:0]         wr_strb;

	function automatic logic [31:0] read_word(input logic [29:0] a);
		if (mem.exists(a))
			return mem[a];
		return {2'b00, a} * 32'h9E37_79B9 + 32'h1234_5678;
	endfunction

	// Stall bits: AR, R, AW, W.
	assign arready = !rd_busy && !stall[0];
	assign awready = !aw_got && !bvalid && !stall[2];
	assign wready = !w_got && !bvalid && !stall[3];
	assign rresp = mem_pkg::OKAY;
	assign bresp = mem_pkg::OKAY;

	// INCR bursts only.
	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_busy <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				rd_busy <= 1'b1;
				rd_addr <= araddr;
				rd_left <= arlen;
			end
			if (rd_busy && !rvalid && !stall[1]) begin
				rvalid <= 1'b1;
				rdata <= read_word(rd_addr[31:2]);
				rlast <= rd_left == 8'd0;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_addr <= rd_addr + 32'd4;
				rd_left <= rd_left - 8'd1;
				if (rlast)
					rd_busy <= 1'b0;
			end
		end
	end

	always @(posedge clock or negedge arst_n) begin
		logic [31:0] word;
		if (!arst_n) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				aw_got <= 1'b1;
				wr_addr <= awaddr;
			end
			if (wvalid && wready) begin
				w_got <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end
			if (aw_got && w_got) begin
				word = read_word(wr_addr[31:2]);
				for (int b = 0; b < 4; b++) begin
					if (wr_strb[b])
						word[8*b +: 8] = wr_data[8*b +: 8];
				end
				mem[wr_addr[31:2]] = word;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module mem_top (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 fetch_valid,
	input  logic [`ADDR_W-1:0]   fetch_addr,
	output logic                 fetch_ready,
	output logic [`DATA_W-1:0]   fetch_inst,
	output mem_pkg::axi_resp_t   fetch_resp,
	output logic                 fetch_done,
	input  logic                 fence_i,
	input  logic                 ld_valid,
	input  logic [`ADDR_W-1:0]   ld_addr,
	input  logic [2:0]           ld_size,
	output logic                 ld_ready,
	output logic [`DATA_W-1:0]   ld_data,
	output mem_pkg::axi_resp_t   ld_resp,
	output logic                 ld_done,
	input  logic                 st_valid,
	input  logic [`ADDR_W-1:0]   st_addr,
	input  logic [`DATA_W-1:0]   st_data,
	input  logic [`DATA_W/8-1:0] st_strb,
	output logic                 st_ready,
	output mem_pkg::axi_resp_t   st_resp,
	output logic                 st_done,
	output logic [`ADDR_W-1:0]   awaddr,
	output logic [7:0]           awlen,
	output logic [2:0]           awsize,
	output logic                 awvalid,
	input  logic                 awready,
	output logic [`DATA_W-1:0]   wdata,
	output logic [`DATA_W/8-1:0] wstrb,
	output logic                 wlast,
	output logic                 wvalid,
	input  logic                 wready,
	input  mem_pkg::axi_resp_t   bresp,
	input  logic                 bvalid,
	output logic                 bready,
	output logic [`ADDR_W-1:0]   araddr,
	output logic [7:0]           arlen,
	output logic [2:0]           arsize,
	output logic                 arvalid,
	input  logic                 arready,
	input  logic [`DATA_W-1:0]   rdata,
	input  mem_pkg::axi_resp_t   rresp,
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready
);

	rd_bus_if fill_bus ();
	rd_bus_if clint_bus ();

	icache u_icache (
		.clock       (clock),
		.arst_n      (arst_n),
		.fetch_valid (fetch_valid),
		.fetch_addr  (fetch_addr),
		.fetch_ready (fetch_ready),
		.fetch_inst  (fetch_inst),
		.fetch_resp  (fetch_resp),
		.fetch_done  (fetch_done),
		.fence_i     (fence_i),
		.fill        (fill_bus)
	);

	// Load, store and AXI ports share their names with the top.
	mem_xbar u_xbar (
		.fill  (fill_bus),
		.clint (clint_bus),
		.*
	);

	clint u_clint (
		.clock  (clock),
		.arst_n (arst_n),
		.bus    (clint_bus)
	);

endmodule

`default_nettype wire

// File: verilog/clint.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module clint (
	input  logic        clock,
	input  logic        arst_n,
	rd_bus_if.responder bus
);

	localparam int OFS_W = $clog2(`CLINT_SIZE);

	logic [63:0]      mtime;
	logic [OFS_W-1:0] ofs;

	assign ofs = bus.araddr[OFS_W-1:0];
	assign bus.arready = 1'b1;
	assign bus.rlast = 1'b1;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mtime <= '0;
			bus.rvalid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (bus.arvalid)
				bus.rvalid <= 1'b1;
			else if (bus.rready)
				bus.rvalid <= 1'b0;
		end
	end

	// Half of mtime as it stands at the AR handshake.
	always_ff @(posedge clock) begin
		if (bus.arvalid) begin
			case (ofs)
				OFS_W'(`MTIME_LO_OFS): begin
					bus.rdata <= mtime[31:0];
					bus.rresp <= mem_pkg::OKAY;
				end
				OFS_W'(`MTIME_HI_OFS): begin
					bus.rdata <= mtime[63:32];
					bus.rresp <= mem_pkg::OKAY;
				end
				default: begin
					bus.rdata <= '0;
					bus.rresp <= mem_pkg::SLVERR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module mem_xbar (
	input  logic                 clock,
	input  logic                 arst_n,
	rd_bus_if.responder          fill,
	rd_bus_if.requester          clint,
	input  logic                 ld_valid,
	input  logic [`ADDR_W-1:0]   ld_addr,
	input  logic [2:0]           ld_size,
	output logic                 ld_ready,
	output logic [`DATA_W-1:0]   ld_data,
	output mem_pkg::axi_resp_t   ld_resp,
	output logic                 ld_done,
	input  logic                 st_valid,
	input  logic [`ADDR_W-1:0]   st_addr,
	input  logic [`DATA_W-1:0]   st_data,
	input  logic [`DATA_W/8-1:0] st_strb,
	output logic                 st_ready,
	output mem_pkg::axi_resp_t   st_resp,
	output logic                 st_done,
	output logic [`ADDR_W-1:0]   awaddr,
	output logic [7:0]           awlen,
	output logic [2:0]           awsize,
	output logic                 awvalid,
	input  logic                 awready,
	output logic [`DATA_W-1:0]   wdata,
	output logic [`DATA_W/8-1:0] wstrb,
	output logic                 wlast,
	output logic                 wvalid,
	input  logic                 wready,
	input  mem_pkg::axi_resp_t   bresp,
	input  logic                 bvalid,
	output logic                 bready,
	output logic [`ADDR_W-1:0]   araddr,
	output logic [7:0]           arlen,
	output logic [2:0]           arsize,
	output logic                 arvalid,
	input  logic                 arready,
	input  logic [`DATA_W-1:0]   rdata,
	input  mem_pkg::axi_resp_t   rresp,
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready
);

	typedef enum logic [1:0] {R_IDLE, R_AR, R_DATA} rd_state_t;
	typedef enum logic [1:0] {OWN_FILL, OWN_LD_AXI, OWN_LD_CLINT} owner_t;
	typedef enum logic [1:0] {W_IDLE, W_SEND, W_RESP} wr_state_t;

	rd_state_t          rd_state;
	owner_t             owner;
	logic [`ADDR_W-1:0] rd_addr;
	logic [7:0]         rd_len;
	logic [2:0]         rd_size;
	logic               ld_beat;
	wr_state_t          wr_state;
	logic               aw_next;
	logic               w_next;

	function automatic logic in_clint(input logic [`ADDR_W-1:0] addr);
		in_clint = addr >= `CLINT_BASE && addr < `CLINT_BASE + `CLINT_SIZE;
	endfunction

	// Loads take priority, so a fill waits while ld_valid is up.
	assign ld_ready = rd_state == R_IDLE;
	assign fill.arready = rd_state == R_IDLE && !ld_valid;

	assign araddr = rd_addr;
	assign arlen = rd_len;
	assign arsize = rd_size;
	assign arvalid = rd_state == R_AR && owner != OWN_LD_CLINT;
	assign clint.araddr = rd_addr;
	assign clint.arlen = rd_len;
	assign clint.arsize = rd_size;
	assign clint.arvalid = rd_state == R_AR && owner == OWN_LD_CLINT;

	// R beats of a fill pass through untouched.
	assign fill.rdata = rdata;
	assign fill.rresp = rresp;
	assign fill.rlast = rlast;
	assign fill.rvalid = rd_state == R_DATA && owner == OWN_FILL && rvalid;
	assign rready = rd_state == R_DATA &&
		(owner == OWN_FILL ? fill.rready : owner == OWN_LD_AXI);
	assign clint.rready = rd_state == R_DATA && owner == OWN_LD_CLINT;

	assign ld_beat = rd_state == R_DATA &&
		(owner == OWN_LD_CLINT ? clint.rvalid : owner == OWN_LD_AXI && rvalid);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= R_IDLE;
			owner <= OWN_FILL;
			ld_done <= 1'b0;
		end else begin
			ld_done <= ld_beat;
			case (rd_state)
				R_IDLE: begin
					if (ld_valid) begin
						owner <= in_clint(ld_addr) ? OWN_LD_CLINT : OWN_LD_AXI;
						rd_state <= R_AR;
					end else if (fill.arvalid) begin
						owner <= OWN_FILL;
						rd_state <= R_AR;
					end
				end
				R_AR: begin
					if (owner == OWN_LD_CLINT ? clint.arready : arready)
						rd_state <= R_DATA;
				end
				R_DATA: begin
					if (ld_beat || (owner == OWN_FILL && rvalid && fill.rready && rlast))
						rd_state <= R_IDLE;
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rd_state == R_IDLE) begin
			if (ld_valid) begin
				rd_addr <= ld_addr;
				rd_len <= '0;
				rd_size <= ld_size;
			end else begin
				rd_addr <= fill.araddr;
				rd_len <= fill.arlen;
				rd_size <= fill.arsize;
			end
		end
		if (ld_beat) begin
			ld_data <= owner == OWN_LD_CLINT ? clint.rdata : rdata;
			ld_resp <= owner == OWN_LD_CLINT ? clint.rresp : rresp;
		end
	end

	// Store side, single-beat word writes.
	assign st_ready = wr_state == W_IDLE;
	assign awlen = '0;
	assign awsize = 3'($clog2(`DATA_W/8));
	assign wlast = 1'b1;
	assign bready = wr_state == W_RESP;
	assign aw_next = awvalid && !awready;
	assign w_next = wvalid && !wready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= W_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			st_done <= 1'b0;
		end else begin
			st_done <= 1'b0;
			case (wr_state)
				W_IDLE: begin
					if (st_valid) begin
						// CLINT is read-only here.
						if (in_clint(st_addr)) begin
							st_done <= 1'b1;
						end else begin
							awvalid <= 1'b1;
							wvalid <= 1'b1;
							wr_state <= W_SEND;
						end
					end
				end
				W_SEND: begin
					awvalid <= aw_next;
					wvalid <= w_next;
					if (!aw_next && !w_next)
						wr_state <= W_RESP;
				end
				W_RESP: begin
					if (bvalid) begin
						st_done <= 1'b1;
						wr_state <= W_IDLE;
					end
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (wr_state == W_IDLE && st_valid) begin
			awaddr <= st_addr;
			wdata <= st_data;
			wstrb <= st_strb;
			st_resp <= mem_pkg::SLVERR;
		end
		if (bready && bvalid)
			st_resp <= bresp;
	end

endmodule

`default_nettype wire

// File: verilog/icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

module icache (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               fetch_valid,
	input  logic [`ADDR_W-1:0] fetch_addr,
	output logic               fetch_ready,
	output logic [`DATA_W-1:0] fetch_inst,
	output mem_pkg::axi_resp_t fetch_resp,
	output logic               fetch_done,
	input  logic               fence_i,
	rd_bus_if.requester        fill
);

	localparam int LINE_W = `ICACHE_WRD_W + 2;

	typedef enum logic [1:0] {S_IDLE, S_AR, S_R} state_t;

	state_t                   state;
	mem_pkg::icache_addr_u    look;
	mem_pkg::icache_addr_u    req;
	logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
	logic [`DATA_W-1:0]       data_mem [`ICACHE_SETS*`ICACHE_WORDS];
	logic [`ICACHE_SETS-1:0]  line_valid;
	logic [`ICACHE_WRD_W-1:0] beat;
	mem_pkg::axi_resp_t       fill_err;
	mem_pkg::axi_resp_t       beat_err;
	logic                     hit;
	logic                     accept;

	// Lookup straight off the incoming address.
	assign look.raw = fetch_addr;
	assign hit = line_valid[look.f.index] && tag_mem[look.f.index] == look.f.tag;
	assign fetch_ready = state == S_IDLE && !fence_i;
	assign accept = fetch_valid && fetch_ready;

	// First error seen in the burst wins.
	assign beat_err = fill_err != mem_pkg::OKAY ? fill_err : fill.rresp;

	// Line-aligned burst of a whole line.
	assign fill.araddr = {req.raw[`ADDR_W-1:LINE_W], {LINE_W{1'b0}}};
	assign fill.arlen = 8'(`ICACHE_WORDS - 1);
	assign fill.arsize = 3'd2;
	assign fill.arvalid = state == S_AR;
	assign fill.rready = state == S_R;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			line_valid <= '0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (fence_i) begin
						line_valid <= '0;
					end else if (fetch_valid) begin
						if (hit)
							fetch_done <= 1'b1;
						else
							state <= S_AR;
					end
				end
				S_AR: begin
					if (fill.arready)
						state <= S_R;
				end
				S_R: begin
					if (fill.rvalid && fill.rlast) begin
						state <= S_IDLE;
						fetch_done <= 1'b1;
						// A line with a bad beat stays invalid.
						line_valid[req.f.index] <= beat_err == mem_pkg::OKAY;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req <= look;
			beat <= '0;
			fill_err <= mem_pkg::OKAY;
			fetch_inst <= data_mem[{look.f.index, look.f.word}];
			fetch_resp <= mem_pkg::OKAY;
		end
		if (state == S_R && fill.rvalid) begin
			data_mem[{req.f.index, beat}] <= fill.rdata;
			beat <= beat + 1'b1;
			fill_err <= beat_err;
			if (beat == req.f.word)
				fetch_inst <= fill.rdata;
			if (fill.rlast) begin
				tag_mem[req.f.index] <= req.f.tag;
				fetch_resp <= beat_err;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/rd_bus_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_defs.svh"

interface rd_bus_if;
	logic [`ADDR_W-1:0] araddr;
	logic [7:0]         arlen;
	logic [2:0]         arsize;
	logic               arvalid;
	logic               arready;
	logic [`DATA_W-1:0] rdata;
	mem_pkg::axi_resp_t rresp;
	logic               rlast;
	logic               rvalid;
	logic               rready;

	// Side that issues the address and takes the beats.
	modport requester (
		output araddr, arlen, arsize, arvalid, rready,
		input  arready, rdata, rresp, rlast, rvalid
	);

	modport responder (
		input  araddr, arlen, arsize, arvalid, rready,
		output arready, rdata, rresp, rlast, rvalid
	);
endinterface

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none
`include "mem_defs.svh"

package mem_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// Fetch address split for the direct-mapped lookup.
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0] tag;
		logic [`ICACHE_IDX_W-1:0] index;
		logic [`ICACHE_WRD_W-1:0] word;
		logic [1:0]               byte_ofs;
	} icache_split_t;

	typedef union packed {
		logic [`ADDR_W-1:0] raw;
		icache_split_t      f;
	} icache_addr_u;

endpackage

`default_nettype wire

// File: verilog/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Bus widths.
`define ADDR_W 32
`define DATA_W 32

// Instruction cache geometry, 16 lines of four words.
`define ICACHE_SETS  16
`define ICACHE_WORDS 4
`define ICACHE_IDX_W ($clog2(`ICACHE_SETS))
`define ICACHE_WRD_W ($clog2(`ICACHE_WORDS))
`define ICACHE_TAG_W (`ADDR_W - `ICACHE_IDX_W - `ICACHE_WRD_W - 2)

// CLINT address map.
`define CLINT_BASE   32'h0200_0000
`define CLINT_SIZE   32'h0001_0000
`define MTIME_LO_OFS 16'hBFF8
`define MTIME_HI_OFS 16'hBFFC

`endif
